/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert --timing
TOP      = sine_gen_tb
FILELIST = src.f
BUILD    = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

/* hw/alu_request.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sine_gen_cfg.svh"

module alu_request (
    input  sine_gen_pkg::seq_task_t tasks,
    input  wire [`SG_SMP_W-1:0]     phase,
    input  wire                     dir,
    input  wire                     sign,
    input  wire [`SG_SMP_W-1:0]     step,
    input  wire [`SG_MIDI_W-1:0]    ampl,
    input  wire [`SG_ACC_W-1:0]     alu_p,
    output logic                    alu_strobe,
    output sine_gen_pkg::alu_op_t   alu_op,
    output logic [`SG_SMP_W-1:0]    alu_a,
    output logic [`SG_SMP_W-1:0]    alu_b,
    output logic [`SG_ACC_W-1:0]    alu_c
);

    localparam int HI_PAD = `SG_ACC_W - `SG_Q_MSB - 1;

    // tasks that issue a request are one-hot per cycle
    always_comb begin
        alu_strobe = 1'b0;
        alu_op     = sine_gen_pkg::ALU_OP_NOP;
        alu_a      = '0;
        alu_b      = '0;
        alu_c      = '0;
        if (tasks.calc_sin) begin
            alu_strobe = 1'b1;
            alu_op     = sine_gen_pkg::ALU_FUNC_SIN;
            alu_a      = phase;
        end else if (tasks.mul_ampl) begin
            // negate on the negative half wave
            alu_strobe             = 1'b1;
            alu_op.dsp.xin_mult    = 1'b1;
            alu_op.dsp.zin_cin     = 1'b1;
            alu_op.dsp.postadd_sub = ~sign;
            alu_a                  = alu_p[`SG_Q_MSB:`SG_Q_LSB];
            alu_b                  = `SG_SMP_W'(ampl) << `SG_AMPL_SHIFT;
        end else if (tasks.add_step) begin
            // phase +/- step, sign picks the operand, dir picks add or sub
            alu_strobe             = 1'b1;
            alu_op.dsp.xin_mult    = 1'b1;
            alu_op.dsp.zin_cin     = 1'b1;
            alu_op.dsp.postadd_sub = ~dir;
            alu_a                  = step;
            alu_b                  = sign ? `SG_PLUS1 : `SG_MINUS1;
            alu_c                  = {{HI_PAD{1'b0}}, phase, {`SG_Q_LSB{1'b0}}};
        end else if (tasks.pi2_minus) begin
            alu_strobe             = 1'b1;
            alu_op.dsp.xin_mult    = 1'b1;
            alu_op.dsp.zin_cin     = 1'b1;
            alu_op.dsp.postadd_sub = 1'b1;
            alu_a                  = alu_p[`SG_Q_MSB:`SG_Q_LSB];
            alu_b                  = `SG_PLUS1;
            alu_c                  = {{HI_PAD{1'b0}}, `SG_PI2, {`SG_Q_LSB{1'b0}}};
        end
    end

endmodule

`default_nettype wire

/* hw/note_voice.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sine_gen_cfg.svh"

module note_voice (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    midi_rdy,
    input  wire [`SG_CMD_W-1:0]    midi_cmd,
    input  wire [`SG_MIDI_W-1:0]   midi_data0,
    input  wire [`SG_MIDI_W-1:0]   midi_data1,
    output logic                   note_on,
    output logic [`SG_MIDI_W-1:0]  ampl,
    output logic [`SG_SMP_W-1:0]   step
);

    logic                  note_on_evt;
    logic                  note_off_evt;
    logic [`SG_MIDI_W-1:0] note;
    logic [`SG_MIDI_W-1:0] note_c;
    logic [`SG_MIDI_W-1:0] octave;
    logic [`SG_MIDI_W-1:0] semi;
    logic [`SG_SMP_W-1:0]  base;

    assign note_on_evt  = midi_rdy && (midi_cmd == `SG_CMD_NOTE_ON);
    assign note_off_evt = midi_rdy && (midi_cmd == `SG_CMD_NOTE_OFF);

    // note-off has priority
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            note    <= '0;
            ampl    <= '0;
            note_on <= 1'b0;
        end else if (note_off_evt) begin
            note    <= '0;
            ampl    <= '0;
            note_on <= 1'b0;
        end else if (note_on_evt) begin
            note    <= midi_data0;
            ampl    <= midi_data1;
            note_on <= 1'b1;
        end
    end

    // --------------------
    // step lookup
    // --------------------
    always_comb begin
        note_c = (note > `SG_MIDI_W'(`SG_MAX_NOTE)) ? `SG_MIDI_W'(`SG_MAX_NOTE) : note;
        octave = note_c / 7'd12;
        semi   = note_c % 7'd12;
    end

    // table holds octave 7, lower octaves shift right
    always_comb begin
        case (semi)
            7'd0:    base = 18'h02311;
            7'd1:    base = 18'h02527;
            7'd2:    base = 18'h0275D;
            7'd3:    base = 18'h029B4;
            7'd4:    base = 18'h02C2F;
            7'd5:    base = 18'h02ECF;
            7'd6:    base = 18'h03198;
            7'd7:    base = 18'h0348B;
            7'd8:    base = 18'h037AB;
            7'd9:    base = 18'h03AFA;
            7'd10:   base = 18'h03E7C;
            default: base = 18'h04233;
        endcase
        // notes 96..99 sit one octave above the table
        if (octave > `SG_MIDI_W'(`SG_TOP_OCTAVE)) begin
            step = base << 1;
        end else begin
            step = base >> (`SG_MIDI_W'(`SG_TOP_OCTAVE) - octave);
        end
    end

endmodule

`default_nettype wire

/* hw/phase_quadrant.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sine_gen_cfg.svh"

module phase_quadrant (
    input  wire                     clk,
    input  wire                     reset,
    input  sine_gen_pkg::seq_task_t tasks,
    input  wire [`SG_ACC_W-1:0]     alu_p,
    output logic [`SG_SMP_W-1:0]    phase,
    output logic                    dir,
    output logic                    sign,
    output logic                    smp_out_rdy,
    output logic [`SG_SMP_W-1:0]    smp_out
);

    logic [`SG_SMP_W-1:0] sin_val;

    // --------------------
    // quarter-wave folding
    // --------------------
    // dir and sign reset to positive
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= '0;
            dir   <= 1'b1;
            sign  <= 1'b1;
        end else if (tasks.min_bound) begin
            phase <= '0;
            sign  <= ~sign;
        end else if (tasks.max_bound) begin
            phase <= `SG_PI2;
            dir   <= ~dir;
        end else if (tasks.mov_phase) begin
            phase <= alu_p[`SG_Q_MSB:`SG_Q_LSB];
        end
    end

    // scaled sine of the current pass
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sin_val <= '0;
        end else if (tasks.mov_sin) begin
            sin_val <= alu_p[`SG_Q_MSB:`SG_Q_LSB];
        end
    end

    // --------------------
    // sample output
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            smp_out_rdy <= 1'b0;
            smp_out     <= '0;
        end else begin
            smp_out_rdy <= tasks.send_smp;
            if (tasks.send_smp) begin
                smp_out <= sin_val;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sine_gen_cfg.svh */
`ifndef SINE_GEN_CFG_SVH
`define SINE_GEN_CFG_SVH

// --------------------
// datapath widths
// --------------------
`define SG_SMP_W        18
`define SG_ACC_W        48
// Q2.16 field inside the accumulator
`define SG_Q_LSB        16
`define SG_Q_MSB        33

// --------------------
// midi
// --------------------
`define SG_MIDI_W       7
`define SG_CMD_W        4
`define SG_CMD_NOTE_ON  4'h9
`define SG_CMD_NOTE_OFF 4'h8
`define SG_MAX_NOTE     99
`define SG_TOP_OCTAVE   7
`define SG_AMPL_SHIFT   9

// --------------------
// sequencer and fixed-point constants
// --------------------
`define SG_PC_W         3
`define SG_PI2          18'h19220
`define SG_PLUS1        18'h10000
`define SG_MINUS1       18'h30000

`endif

/* hw/sine_gen_pkg.sv */
`default_nettype none

package sine_gen_pkg;

    // dsp view of the alu opcode
    typedef struct packed {
        logic       func;
        logic       xin_mult;
        logic       zin_cin;
        logic       postadd_sub;
        logic [4:0] rsvd;
    } alu_dsp_t;

    // function view, selected by the func flag
    typedef struct packed {
        logic       func;
        logic [7:0] code;
    } alu_fn_t;

    typedef union packed {
        alu_dsp_t dsp;
        alu_fn_t  fn;
    } alu_op_t;

    localparam alu_op_t ALU_OP_NOP   = 9'h000;
    // func flag set, function code 1
    localparam alu_op_t ALU_FUNC_SIN = 9'h101;

    // one flag per sequencer task, several may be active in one cycle
    typedef struct packed {
        logic jump_home;
        logic send_smp;
        logic set_cycle;
        logic clr_cycle;
        logic calc_sin;
        logic mul_ampl;
        logic add_step;
        logic pi2_minus;
        logic wait_hold;
        logic mov_phase;
        logic mov_sin;
        logic min_bound;
        logic max_bound;
    } seq_task_t;

endpackage

`default_nettype wire

/* hw/sine_gen_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sine_gen_cfg.svh"

module sine_gen_top (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    midi_rdy,
    input  wire [`SG_CMD_W-1:0]    midi_cmd,
    input  wire [`SG_MIDI_W-1:0]   midi_data0,
    input  wire [`SG_MIDI_W-1:0]   midi_data1,
    input  wire                    smp_trig,
    output logic                   smp_out_rdy,
    output logic [`SG_SMP_W-1:0]   smp_out,
    output logic                   alu_cycle,
    output logic                   alu_strobe,
    input  wire                    alu_ack,
    input  wire                    alu_stall,
    output sine_gen_pkg::alu_op_t  alu_op,
    output logic [`SG_SMP_W-1:0]   alu_a,
    output logic [`SG_SMP_W-1:0]   alu_b,
    output logic [`SG_ACC_W-1:0]   alu_c,
    input  wire [`SG_ACC_W-1:0]    alu_p
);

    logic                    note_on;
    logic [`SG_MIDI_W-1:0]   ampl;
    logic [`SG_SMP_W-1:0]    step;
    logic [`SG_SMP_W-1:0]    phase;
    logic                    dir;
    logic                    sign;
    sine_gen_pkg::seq_task_t tasks;

    note_voice u_note_voice (
        .clk        (clk),
        .reset      (reset),
        .midi_rdy   (midi_rdy),
        .midi_cmd   (midi_cmd),
        .midi_data0 (midi_data0),
        .midi_data1 (midi_data1),
        .note_on    (note_on),
        .ampl       (ampl),
        .step       (step)
    );

    // result sign comes straight from the accumulator msb
    sine_sequencer u_sine_sequencer (
        .clk        (clk),
        .reset      (reset),
        .note_on    (note_on),
        .smp_trig   (smp_trig),
        .alu_stall  (alu_stall),
        .alu_ack    (alu_ack),
        .result_neg (alu_p[`SG_ACC_W-1]),
        .tasks      (tasks),
        .alu_cycle  (alu_cycle)
    );

    phase_quadrant u_phase_quadrant (
        .clk         (clk),
        .reset       (reset),
        .tasks       (tasks),
        .alu_p       (alu_p),
        .phase       (phase),
        .dir         (dir),
        .sign        (sign),
        .smp_out_rdy (smp_out_rdy),
        .smp_out     (smp_out)
    );

    alu_request u_alu_request (
        .tasks      (tasks),
        .phase      (phase),
        .dir        (dir),
        .sign       (sign),
        .step       (step),
        .ampl       (ampl),
        .alu_p      (alu_p),
        .alu_strobe (alu_strobe),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_c      (alu_c)
    );

endmodule

`default_nettype wire

/* hw/sine_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sine_gen_cfg.svh"

module sine_sequencer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     note_on,
    input  wire                     smp_trig,
    input  wire                     alu_stall,
    input  wire                     alu_ack,
    input  wire                     result_neg,
    output sine_gen_pkg::seq_task_t tasks,
    output logic                    alu_cycle
);

    logic [`SG_PC_W-1:0] pc;

    // --------------------
    // task decode
    // --------------------
    always_comb begin
        tasks = '0;
        case (pc)
            `SG_PC_W'(0): begin
                tasks.wait_hold = !note_on;
            end
            `SG_PC_W'(1): begin
                // a note-off while waiting sends the sequencer home
                tasks.wait_hold = !smp_trig;
                tasks.jump_home = !note_on;
                tasks.send_smp  = smp_trig && note_on;
                tasks.set_cycle = smp_trig && note_on;
            end
            `SG_PC_W'(2): begin
                tasks.wait_hold = alu_stall;
                tasks.calc_sin  = !alu_stall;
            end
            `SG_PC_W'(3): begin
                tasks.wait_hold = !alu_ack;
                tasks.mul_ampl  = alu_ack;
            end
            `SG_PC_W'(4): begin
                tasks.add_step  = 1'b1;
            end
            `SG_PC_W'(5): begin
                tasks.wait_hold = !alu_ack;
                tasks.mov_sin   = alu_ack;
            end
            `SG_PC_W'(6): begin
                // negative phase means the minimum bound was crossed
                tasks.wait_hold = !alu_ack;
                tasks.mov_phase = alu_ack;
                tasks.min_bound = alu_ack && result_neg;
                tasks.clr_cycle = alu_ack && result_neg;
                tasks.jump_home = alu_ack && result_neg;
                tasks.pi2_minus = alu_ack && !result_neg;
            end
            default: begin
                // pc 7, result of pi/2 - phase
                tasks.wait_hold = !alu_ack;
                tasks.max_bound = alu_ack && result_neg;
                tasks.clr_cycle = alu_ack;
                tasks.jump_home = alu_ack;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (tasks.jump_home) begin
            pc <= '0;
        end else if (!tasks.wait_hold) begin
            pc <= pc + `SG_PC_W'(1);
        end
    end

    // high for the whole alu pass
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_cycle <= 1'b0;
        end else if (tasks.set_cycle) begin
            alu_cycle <= 1'b1;
        end else if (tasks.clr_cycle) begin
            alu_cycle <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/sine_gen_pkg.sv
hw/note_voice.sv
hw/sine_sequencer.sv
hw/phase_quadrant.sv
hw/alu_request.sv
hw/sine_gen_top.sv
verif/sine_gen_chk.sv
verif/sine_gen_tb.sv

/* verif/sine_cases.txt */
# cmd(hex) note velocity triggers
# cmd 9 is note-on, 8 is note-off, 0 sends no midi event
0 0 0 3
9 69 100 4
9 30 64 4
9 12 127 3
9 47 90 3
9 96 80 3
9 99 127 14
9 110 45 8
8 0 0 3
9 60 20 4
8 64 0 2
9 120 127 6
9 98 70 5
8 0 0 2

/* verif/sine_gen_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module sine_gen_chk (
    input wire       clk,
    input wire       reset,
    input wire       alu_strobe,
    input wire       alu_cycle,
    input wire       alu_stall,
    input wire       smp_out_rdy,
    input wire [8:0] alu_op
);

    // requests only inside a pass
    strobe_in_cycle: assert property (@(posedge clk) disable iff (reset)
        alu_strobe |-> alu_cycle)
        else $error("alu strobe outside an alu cycle");

    // sample strobe is a single pulse
    smp_rdy_pulse: assert property (@(posedge clk) disable iff (reset)
        smp_out_rdy |=> !smp_out_rdy)
        else $error("smp_out_rdy held longer than one cycle");

    // sin goes out only while the alu takes it
    sin_not_stalled: assert property (@(posedge clk) disable iff (reset)
        (alu_strobe && alu_op[8]) |-> !alu_stall)
        else $error("sin request issued during alu stall");

endmodule

bind sine_gen_top sine_gen_chk chk0 (
    .clk         (clk),
    .reset       (reset),
    .alu_strobe  (alu_strobe),
    .alu_cycle   (alu_cycle),
    .alu_stall   (alu_stall),
    .smp_out_rdy (smp_out_rdy),
    .alu_op      (alu_op)
);

`default_nettype wire

/* verif/sine_gen_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sine_gen_cfg.svh"

module sine_gen_tb;

    localparam logic [8:0] OP_SIN = 9'h101;

    logic        clk = 1'b0;
    logic        reset;
    logic        midi_rdy;
    logic [3:0]  midi_cmd;
    logic [6:0]  midi_data0;
    logic [6:0]  midi_data1;
    logic        smp_trig;
    logic        smp_out_rdy;
    logic [17:0] smp_out;
    logic        alu_cycle;
    logic        alu_strobe;
    logic        alu_ack;
    logic        alu_stall;
    logic [8:0]  alu_op;
    logic [17:0] alu_a;
    logic [17:0] alu_b;
    logic [47:0] alu_c;
    logic [47:0] alu_p;

    integer seed = 79625;
    int     value_errors = 0;
    int     protocol_errors = 0;
    int     cyc = 0;
    int     last_rdy = 0;
    int     wd_limit = 0;
    logic   cases_loaded = 1'b0;
    logic   cases_ok = 1'b0;

    // cases read from file
    int cs_cmd[$];
    int cs_note[$];
    int cs_vel[$];
    int cs_trig[$];

    // expected requests and samples
    logic [8:0]  exp_op_q[$];
    logic [17:0] exp_a_q[$];
    logic [17:0] exp_b_q[$];
    logic [47:0] exp_c_q[$];
    logic [17:0] exp_smp_q[$];

    // alu results waiting for their ack
    logic [47:0] res_q[$];
    int          res_rdy_q[$];

    // reference state
    logic        m_on = 1'b0;
    logic [6:0]  m_ampl = '0;
    logic [17:0] m_step = '0;
    logic [17:0] m_phase = '0;
    logic        m_dir = 1'b1;
    logic        m_sign = 1'b1;
    logic [17:0] m_last_q = '0;

    sine_gen_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .midi_rdy    (midi_rdy),
        .midi_cmd    (midi_cmd),
        .midi_data0  (midi_data0),
        .midi_data1  (midi_data1),
        .smp_trig    (smp_trig),
        .smp_out_rdy (smp_out_rdy),
        .smp_out     (smp_out),
        .alu_cycle   (alu_cycle),
        .alu_strobe  (alu_strobe),
        .alu_ack     (alu_ack),
        .alu_stall   (alu_stall),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_c       (alu_c),
        .alu_p       (alu_p)
    );

    always #20 clk = ~clk;

    // --------------------
    // helpers
    // --------------------
    task automatic compare_value(input string name, input logic [47:0] exp,
                                 input logic [47:0] got);
        assert (exp == got) else begin
            value_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        protocol_errors++;
        $display("%0t: %s", $time, msg);
    endtask

    function automatic logic [8:0] dsp_op(input logic sub);
        return {1'b0, 1'b1, 1'b1, sub, 5'b0};
    endfunction

    // octave 7 table, shifted per octave, notes clamp at 99
    function automatic logic [17:0] octave_step(input int note);
        int          n;
        logic [17:0] base;
        n = (note > 99) ? 99 : note;
        case (n % 12)
            0:       base = 18'h02311;
            1:       base = 18'h02527;
            2:       base = 18'h0275D;
            3:       base = 18'h029B4;
            4:       base = 18'h02C2F;
            5:       base = 18'h02ECF;
            6:       base = 18'h03198;
            7:       base = 18'h0348B;
            8:       base = 18'h037AB;
            9:       base = 18'h03AFA;
            10:      base = 18'h03E7C;
            default: base = 18'h04233;
        endcase
        if (n >= 96) begin
            return base << 1;
        end
        return base >> (7 - n / 12);
    endfunction

    // p = c +/- a*b, or the operand itself for sin
    function automatic logic [47:0] alu_result(input logic [8:0] op, input logic [17:0] a,
                                               input logic [17:0] b, input logic [47:0] c);
        logic signed [47:0] sa;
        logic signed [47:0] sb;
        logic signed [47:0] prod;
        sa   = $signed({{30{a[17]}}, a});
        sb   = $signed({{30{b[17]}}, b});
        prod = sa * sb;
        if (op[8]) begin
            return {14'h0, a, 16'h0};
        end
        if (op[5]) begin
            return c - prod;
        end
        return c + prod;
    endfunction

    task automatic push_req(input logic [8:0] op, input logic [17:0] a,
                            input logic [17:0] b, input logic [47:0] c);
        exp_op_q.push_back(op);
        exp_a_q.push_back(a);
        exp_b_q.push_back(b);
        exp_c_q.push_back(c);
    endtask

    // --------------------
    // reference model, one pass
    // --------------------
    task automatic predict_pass();
        longint prod;
        longint nxt;
        push_req(OP_SIN, m_phase, 18'h0, 48'h0);
        push_req(dsp_op(!m_sign), m_phase, 18'(m_ampl) << `SG_AMPL_SHIFT, 48'h0);
        prod = longint'(m_phase) * longint'(m_ampl) * 512;
        if (!m_sign) begin
            prod = -prod;
        end
        exp_smp_q.push_back(m_last_q);
        m_last_q = prod[33:16];
        push_req(dsp_op(!m_dir), m_step, m_sign ? `SG_PLUS1 : `SG_MINUS1,
                 {14'h0, m_phase, 16'h0});
        // moving up when dir and sign agree
        nxt = longint'(m_phase) + ((m_dir == m_sign) ? longint'(m_step) : -longint'(m_step));
        if (nxt < 0) begin
            m_sign  = !m_sign;
            m_phase = '0;
        end else begin
            m_phase = nxt[17:0];
            push_req(dsp_op(1'b1), m_phase, `SG_PLUS1, {14'h0, `SG_PI2, 16'h0});
            if (longint'(`SG_PI2) - longint'(m_phase) < 0) begin
                m_dir   = !m_dir;
                m_phase = `SG_PI2;
            end
        end
    endtask

    // --------------------
    // alu model and request monitor
    // --------------------
    always @(posedge clk) begin
        int lat;
        cyc = cyc + 1;
        if (!reset) begin
            if (alu_strobe) begin
                assert (exp_op_q.size() > 0) else report_failure("unexpected alu request");
                if (exp_op_q.size() > 0) begin
                    compare_value("alu_op", 48'(exp_op_q.pop_front()), 48'(alu_op));
                    compare_value("alu_a", 48'(exp_a_q.pop_front()), 48'(alu_a));
                    compare_value("alu_b", 48'(exp_b_q.pop_front()), 48'(alu_b));
                    compare_value("alu_c", exp_c_q.pop_front(), alu_c);
                end
                lat = 1 + ($random(seed) & 3);
                if (cyc + lat <= last_rdy) begin
                    last_rdy = last_rdy + 1;
                end else begin
                    last_rdy = cyc + lat;
                end
                res_q.push_back(alu_result(alu_op, alu_a, alu_b, alu_c));
                res_rdy_q.push_back(last_rdy);
            end
            if (smp_out_rdy) begin
                assert (exp_smp_q.size() > 0) else report_failure("unexpected output sample");
                if (exp_smp_q.size() > 0) begin
                    compare_value("smp_out", 48'(exp_smp_q.pop_front()), 48'(smp_out));
                end
            end
        end
    end

    // results in order, stall random
    always @(negedge clk) begin
        alu_stall = (($random(seed) & 3) == 0);
        if (res_q.size() > 0 && res_rdy_q[0] <= cyc) begin
            alu_ack = 1'b1;
            alu_p   = res_q.pop_front();
            res_rdy_q.pop_front();
        end else begin
            alu_ack = 1'b0;
            alu_p   = '0;
        end
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic load_cases();
        int    fd;
        int    cmd;
        int    nt;
        int    vl;
        int    tr;
        int    total;
        string line;
        total = 0;
        fd = $fopen("verif/sine_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %d %d %d", cmd, nt, vl, tr) == 4) begin
                        cs_cmd.push_back(cmd);
                        cs_note.push_back(nt);
                        cs_vel.push_back(vl);
                        cs_trig.push_back(tr);
                        total = total + tr;
                    end
                end
            end
            $fclose(fd);
            cases_ok = 1'b1;
        end
        wd_limit     = total * 40 + 200;
        cases_loaded = 1'b1;
    endtask

    task automatic apply_midi(input int cmd, input int note, input int vel);
        @(negedge clk);
        midi_rdy   = 1'b1;
        midi_cmd   = 4'(cmd);
        midi_data0 = 7'(note);
        midi_data1 = 7'(vel);
        @(negedge clk);
        midi_rdy = 1'b0;
        if (cmd == `SG_CMD_NOTE_ON) begin
            m_on   = 1'b1;
            m_ampl = 7'(vel);
            m_step = octave_step(note);
        end else if (cmd == `SG_CMD_NOTE_OFF) begin
            m_on = 1'b0;
        end
    endtask

    task automatic run_trigger();
        repeat (3) @(negedge clk);
        if (m_on) begin
            predict_pass();
        end
        smp_trig = 1'b1;
        @(negedge clk);
        smp_trig = 1'b0;
        if (m_on) begin
            while (alu_cycle) @(negedge clk);
            assert (exp_op_q.size() == 0) else report_failure("pass ended with requests missing");
        end else begin
            repeat (4) @(negedge clk);
            assert (!alu_cycle) else report_failure("alu cycle started with no note on");
        end
    endtask

    initial begin
        reset      = 1'b1;
        midi_rdy   = 1'b0;
        midi_cmd   = '0;
        midi_data0 = '0;
        midi_data1 = '0;
        smp_trig   = 1'b0;
        alu_ack    = 1'b0;
        alu_stall  = 1'b0;
        alu_p      = '0;
        load_cases();
        if (!cases_ok) begin
            $display("could not open the case file");
            $display("Simulation failed");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            assert (!alu_cycle && !alu_strobe && !smp_out_rdy)
                else report_failure("outputs not idle after reset");
            for (int i = 0; i < cs_cmd.size(); i++) begin
                if (cs_cmd[i] != 0) begin
                    apply_midi(cs_cmd[i], cs_note[i], cs_vel[i]);
                end
                for (int t = 0; t < cs_trig[i]; t++) begin
                    run_trigger();
                end
            end
            repeat (6) @(negedge clk);
            assert (exp_smp_q.size() == 0) else report_failure("expected samples never appeared");
            $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
            if (value_errors + protocol_errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // watchdog sized from the trigger count
    initial begin
        wait (cases_loaded);
        repeat (wd_limit) @(posedge clk);
        $display("timeout, the run did not finish in %0d cycles", wd_limit);
        $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
